//--- hdl/isa_pkg.sv
/*
 * Instruction set encodings
 *   major opcode and jump condition enums
 *   instruction word with its register and jump views
 *   sub-codes of the shift/misc group
 */
package isa_pkg;

	// ------------------------------------------------------------------------
	// Major opcode, instruction bits 15:11
	typedef enum logic [4:0] {
		OP_ALU     = 5'b00000,	// ADD SUB ADC SBC by fn
		OP_LOGIC   = 5'b00001,	// AND OR XOR BIC by fn
		OP_ADDI    = 5'b00010,
		OP_SUBI    = 5'b00011,
		OP_ADCI    = 5'b00100,
		OP_SBCI    = 5'b00101,
		OP_ANDI    = 5'b00110,
		OP_ORI     = 5'b00111,
		OP_XORI    = 5'b01000,
		OP_CMPI    = 5'b01001,	// SUBI without register write
		OP_LDI     = 5'b01010,
		OP_MISC    = 5'b01011,	// Rotates, shifts, NOT/NEG, JIND
		OP_LD      = 5'b01100,
		OP_ST      = 5'b01101,
		OP_JAL     = 5'b01110,	// Bit 11 is the offset sign
		OP_JAL_NEG = 5'b01111,
		OP_JUMP    = 5'b10000	// Only bit 15 matters, rest is cond/offset
	} op_major_t;

	// Jump condition, bits 14:12 of a jump
	typedef enum logic [2:0] {
		C_Z  = 3'd0,
		C_NZ = 3'd1,
		C_C  = 3'd2,
		C_NC = 3'd3,
		C_N  = 3'd4,
		C_NN = 3'd5,
		C_V  = 3'd6,
		C_AL = 3'd7	// Always
	} cond_t;

	// ------------------------------------------------------------------------
	// Instruction word views
	typedef struct packed {
		op_major_t   op;
		logic [2:0]  rd;	// Destination, also A source of immediates
		logic [2:0]  ra;	// A source or misc sub-code
		logic [2:0]  rb;	// B source
		logic [1:0]  fn;	// Function select
	} inst_reg_t;

	typedef struct packed {
		logic        jf;	// Set for conditional jumps
		cond_t       cond;
		logic [11:0] off;	// Signed word offset
	} inst_jump_t;

	typedef union packed {
		inst_reg_t  r;
		inst_jump_t j;
	} inst_word_t;

	// Sub-codes in the ra field of OP_MISC
	localparam logic       SUB_MISC_ROT = 1'b0;	// Compared with ra[2] only
	localparam logic [2:0] SUB_SHIFT    = 3'b100;
	localparam logic [2:0] SUB_UNARY    = 3'b101;
	localparam logic [2:0] SUB_JUMP     = 3'b111;

endpackage

//--- hdl/core_pkg.sv
/*
 * Core datapath definitions
 *   word and register index widths, link register
 *   ALU function and shift select enums
 *   decoded control struct passed between the stages
 */
package core_pkg;

	localparam int WORD_W = 16;
	localparam int REG_W  = 3;

	localparam logic [REG_W-1:0] LINK_REG = 3'd6;	// JAL return address

	// Immediate source
	localparam logic [1:0] IMM_OFF5 = 2'd0;	// LD/ST offset
	localparam logic [1:0] IMM_BYTE = 2'd1;	// ALU immediates, LDI
	localparam logic [1:0] IMM_REL  = 2'd2;	// Jumps and JAL

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_XOR = 2'd1,
		ALU_OR  = 2'd2,
		ALU_AND = 2'd3
	} alu_op_t;

	typedef enum logic [1:0] {
		SH_NONE = 2'd0,	// Plain rotate, bit 0 wraps
		SH_SHR  = 2'd1,
		SH_SHRA = 2'd2,
		SH_RORC = 2'd3
	} shift_t;

	typedef struct packed {
		alu_op_t           alu_op;
		logic              zero_a;	// Force operand A to zero
		logic              inv_b;	// Also carry-in when not from flag
		logic              carry_flag;	// Carry-in from C
		shift_t            shift;
		logic [3:0]        rot;	// Right rotate amount
		logic              imm_sel;	// B from immediate
		logic [1:0]        imm_src;
		logic              write_reg;
		logic              write_cv;
		logic              write_zn;
		logic              pc_a;	// A from PC
		logic              ld;
		logic              st;
		logic              jal;
		logic              jind;
		isa_pkg::cond_t    cond;
		logic              jcond;	// Conditional relative jump
		logic [REG_W-1:0]  rd;
		logic [REG_W-1:0]  ra;
		logic [REG_W-1:0]  rb;
	} ctrl_t;

endpackage

//--- hdl/gus_decode.sv
/*
 * Decode stage
 *   instruction register and valid bit
 *   control truth table over the register and jump views
 *   immediate builder
 */
`timescale 1ns/100ps

module gus_decode (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [core_pkg::WORD_W-1:0] mem_rdata,
	input  logic                        jump_taken,
	input  logic                        ld_st,
	output core_pkg::ctrl_t             ctrl,
	output logic                        op_valid,
	output logic [core_pkg::WORD_W-1:0] imm
);
	import core_pkg::*;
	import isa_pkg::*;

	inst_word_t ir;
	logic       illegal;

	always_ff @(posedge clk) begin
		ir <= mem_rdata;	// Fetched every cycle
	end

	// Word fetched during LD/ST or a taken jump is dropped
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= !(ld_st || jump_taken);
		end
	end

	// ------------------------------------------------------------------------
	// Control truth table
	always_comb begin
		ctrl         = '0;
		illegal      = 1'b0;
		ctrl.rd      = ir.r.rd;
		ctrl.ra      = ir.r.ra;
		ctrl.rb      = ir.r.rb;
		ctrl.imm_src = IMM_BYTE;
		if (ir.j.jf) begin	// Jump view
			ctrl.cond    = ir.j.cond;
			ctrl.jcond   = 1'b1;
			ctrl.pc_a    = 1'b1;	// Target = PC + offset
			ctrl.imm_sel = 1'b1;
			ctrl.imm_src = IMM_REL;
		end else begin
			case (ir.r.op)
				OP_ALU: begin
					ctrl.inv_b      = ir.r.fn[0];	// SUB, SBC
					ctrl.carry_flag = ir.r.fn[1];	// ADC, SBC
					ctrl.write_reg  = 1'b1;
					ctrl.write_cv   = 1'b1;
					ctrl.write_zn   = 1'b1;
				end
				OP_LOGIC: begin
					case (ir.r.fn)
						2'b00: ctrl.alu_op = ALU_AND;
						2'b01: ctrl.alu_op = ALU_OR;
						2'b10: ctrl.alu_op = ALU_XOR;
						default: begin
							ctrl.alu_op = ALU_AND;	// BIC
							ctrl.inv_b  = 1'b1;
						end
					endcase
					ctrl.write_reg = 1'b1;
					ctrl.write_zn  = 1'b1;
				end
				OP_ADDI, OP_SUBI, OP_ADCI, OP_SBCI, OP_CMPI: begin
					ctrl.ra         = ir.r.rd;
					ctrl.imm_sel    = 1'b1;
					ctrl.inv_b      = ir.r.op inside {OP_SUBI, OP_SBCI, OP_CMPI};
					ctrl.carry_flag = ir.r.op inside {OP_ADCI, OP_SBCI};
					ctrl.write_reg  = (ir.r.op != OP_CMPI);	// CMPI only flags
					ctrl.write_cv   = 1'b1;
					ctrl.write_zn   = 1'b1;
				end
				OP_ANDI, OP_ORI, OP_XORI: begin
					ctrl.alu_op    = (ir.r.op == OP_ANDI) ? ALU_AND :
					                 (ir.r.op == OP_ORI) ? ALU_OR : ALU_XOR;
					ctrl.ra        = ir.r.rd;
					ctrl.imm_sel   = 1'b1;
					ctrl.write_reg = 1'b1;
					ctrl.write_zn  = 1'b1;
				end
				OP_LDI: begin
					ctrl.alu_op    = ALU_OR;	// 0 | imm
					ctrl.zero_a    = 1'b1;
					ctrl.imm_sel   = 1'b1;
					ctrl.write_reg = 1'b1;
				end
				OP_MISC: begin
					ctrl.alu_op = ALU_OR;	// Passes rb through
					ctrl.zero_a = 1'b1;
					if (ir.r.ra[2] == SUB_MISC_ROT) begin	// RORI
						ctrl.rot       = {ir.r.ra[1:0], ir.r.fn};
						ctrl.write_reg = 1'b1;
						ctrl.write_zn  = 1'b1;
					end else begin
						case (ir.r.ra)
							SUB_SHIFT: begin
								ctrl.rot       = 4'd1;
								ctrl.write_reg = 1'b1;
								ctrl.write_cv  = 1'b1;
								ctrl.write_zn  = 1'b1;
								case (ir.r.fn)
									2'b00: ctrl.shift = SH_RORC;
									2'b01: ctrl.shift = SH_SHR;
									2'b10: ctrl.shift = SH_SHRA;
									default: illegal = 1'b1;
								endcase
							end
							SUB_UNARY: begin
								ctrl.inv_b     = 1'b1;	// NOT, NEG = 0 + ~b + 1
								ctrl.write_reg = 1'b1;
								ctrl.write_zn  = 1'b1;
								if (ir.r.fn == 2'b01) begin
									ctrl.alu_op = ALU_ADD;
								end
								illegal = ir.r.fn[1];
							end
							SUB_JUMP: begin
								ctrl.jind = (ir.r.fn == 2'b10);
								illegal   = (ir.r.fn != 2'b10);	// LDPC, RETI dropped
							end
							default: illegal = 1'b1;
						endcase
					end
				end
				OP_LD, OP_ST: begin
					ctrl.imm_sel   = 1'b1;
					ctrl.imm_src   = IMM_OFF5;
					ctrl.ld        = (ir.r.op == OP_LD);
					ctrl.st        = (ir.r.op == OP_ST);
					ctrl.rb        = ir.r.rd;	// Store data
					ctrl.write_reg = (ir.r.op == OP_LD);
					ctrl.write_zn  = (ir.r.op == OP_LD);
				end
				OP_JAL, OP_JAL_NEG: begin
					ctrl.pc_a      = 1'b1;
					ctrl.imm_sel   = 1'b1;
					ctrl.imm_src   = IMM_REL;
					ctrl.jal       = 1'b1;
					ctrl.rd        = LINK_REG;
					ctrl.write_reg = 1'b1;
				end
				default: illegal = 1'b1;
			endcase
		end
		if (illegal) begin	// Executes as a no-op
			ctrl.write_reg = 1'b0;
			ctrl.write_cv  = 1'b0;
			ctrl.write_zn  = 1'b0;
		end
	end

	// Low bits are shared by every format
	always_comb begin
		case (ctrl.imm_src)
			IMM_OFF5: imm = {{(WORD_W-5){1'b0}}, ir.j.off[4:0]};
			IMM_BYTE: imm = {{(WORD_W-8){1'b0}}, ir.j.off[7:0]};
			default:  imm = {{(WORD_W-12){ir.j.off[11]}}, ir.j.off};
		endcase
	end

	// A memory op drops the next word
	a_mem_drop: assert property (@(posedge clk) disable iff (reset)
		op_valid && (ctrl.ld || ctrl.st) |=> !op_valid);

	a_no_illegal: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> !illegal)
		else $error("illegal opcode %h executed", ir);

endmodule

//--- hdl/gus_execute.sv
/*
 * Execute stage
 *   operand select, add/logic unit with carry and overflow
 *   four-stage barrel rotator with shift-in choice
 *   C/V/Z/N flag register and jump condition
 */
`timescale 1ns/100ps

module gus_execute (
	input  logic                        clk,
	input  logic                        reset,
	input  core_pkg::ctrl_t             ctrl,
	input  logic                        op_valid,
	input  logic [core_pkg::WORD_W-1:0] imm,
	input  logic [core_pkg::WORD_W-1:0] reg_a,
	input  logic [core_pkg::WORD_W-1:0] reg_b,
	input  logic [core_pkg::WORD_W-1:0] pc_now,
	input  logic [core_pkg::WORD_W-1:0] mem_rdata,
	output logic [core_pkg::WORD_W-1:0] alu_y,
	output logic [core_pkg::WORD_W-1:0] mem_addr,
	output logic                        mem_we,
	output logic [core_pkg::WORD_W-1:0] mem_wdata,
	output logic                        jump_taken
);
	import core_pkg::*;
	import isa_pkg::*;

	typedef struct packed {
		logic c;
		logic v;
		logic z;
		logic n;
	} flags_t;

	flags_t            flags;
	logic [WORD_W-1:0] op_a, op_b, sa, sb;
	logic [WORD_W-1:0] sum;
	logic [WORD_W-1:0] bsi, rot8, rot4, rot2, rot_y;
	logic              cin, cout, ovf;
	logic              shift_in, cond_true;

	// ------------------------------------------------------------------------
	// Operands and add/logic unit
	assign op_a = ctrl.pc_a ? pc_now : reg_a;
	assign op_b = ctrl.imm_sel ? imm : reg_b;
	assign sa   = ctrl.zero_a ? '0 : op_a;
	assign sb   = ctrl.inv_b ? ~op_b : op_b;
	assign cin  = ctrl.carry_flag ? flags.c : ctrl.inv_b;	// +1 for SUB/NEG

	always_comb begin
		cout = 1'b0;
		case (ctrl.alu_op)
			ALU_ADD: {cout, sum} = {1'b0, sa} + {1'b0, sb} + {{WORD_W{1'b0}}, cin};
			ALU_XOR: sum = sa ^ sb;
			ALU_OR:  sum = sa | sb;
			default: sum = sa & sb;
		endcase
	end

	// Signed overflow of the adder
	assign ovf = (~sa[WORD_W-1] & ~sb[WORD_W-1] & sum[WORD_W-1]) |
	             (sa[WORD_W-1] & sb[WORD_W-1] & ~sum[WORD_W-1]);

	// ------------------------------------------------------------------------
	// Barrel rotator, right by ctrl.rot
	always_comb begin
		case (ctrl.shift)
			SH_SHR:  shift_in = 1'b0;
			SH_SHRA: shift_in = sum[WORD_W-1];	// Sign copy
			SH_RORC: shift_in = flags.c;
			default: shift_in = sum[0];	// Plain rotate
		endcase
	end

	assign bsi   = {sum[WORD_W-1:1], shift_in};	// Bit 0 becomes the new MSB
	assign rot8  = ctrl.rot[3] ? {bsi[7:0], bsi[15:8]} : bsi;
	assign rot4  = ctrl.rot[2] ? {rot8[3:0], rot8[15:4]} : rot8;
	assign rot2  = ctrl.rot[1] ? {rot4[1:0], rot4[15:2]} : rot4;
	assign rot_y = ctrl.rot[0] ? {rot2[0], rot2[15:1]} : rot2;

	assign alu_y = ctrl.ld ? mem_rdata : rot_y;	// Load data joins here

	// ------------------------------------------------------------------------
	// Memory bus
	assign mem_addr  = (op_valid && (ctrl.ld || ctrl.st)) ? sum : pc_now;
	assign mem_we    = op_valid && ctrl.st;
	assign mem_wdata = reg_b;

	// Flag register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flags <= '0;
		end else if (op_valid) begin
			if (ctrl.write_cv) begin
				flags.c <= (ctrl.shift != SH_NONE) ? op_b[0] : cout;	// Shifted-out bit
				flags.v <= ovf;
			end
			if (ctrl.write_zn) begin
				flags.z <= (alu_y == '0);
				flags.n <= alu_y[WORD_W-1];
			end
		end
	end

	// Jump condition
	always_comb begin
		case (ctrl.cond)
			C_Z:     cond_true = flags.z;
			C_NZ:    cond_true = !flags.z;
			C_C:     cond_true = flags.c;
			C_NC:    cond_true = !flags.c;
			C_N:     cond_true = flags.n;
			C_NN:    cond_true = !flags.n;
			C_V:     cond_true = flags.v;
			default: cond_true = 1'b1;
		endcase
	end

	assign jump_taken = op_valid && ((ctrl.jcond && cond_true) || ctrl.jal || ctrl.jind);

	// Store strobe lasts one cycle, the refetch follows
	a_we_store: assert property (@(posedge clk) disable iff (reset)
		mem_we |=> !mem_we);

endmodule

//--- hdl/gus_result.sv
/*
 * Result stage
 *   eight-entry register file with JAL link write
 *   program counter
 */
`timescale 1ns/100ps

module gus_result (
	input  logic                        clk,
	input  logic                        reset,
	input  core_pkg::ctrl_t             ctrl,
	input  logic                        op_valid,
	input  logic [core_pkg::WORD_W-1:0] alu_y,
	input  logic                        jump_taken,
	output logic [core_pkg::WORD_W-1:0] reg_a,
	output logic [core_pkg::WORD_W-1:0] reg_b,
	output logic [core_pkg::WORD_W-1:0] pc_now
);
	import core_pkg::*;

	logic [WORD_W-1:0] regs [2**REG_W];
	logic [WORD_W-1:0] pc;
	logic              mem_op;

	assign mem_op = op_valid && (ctrl.ld || ctrl.st);

	// Register file
	always_ff @(posedge clk) begin
		if (op_valid && ctrl.write_reg) begin
			regs[ctrl.rd] <= ctrl.jal ? pc : alu_y;	// Link = jump address + 1
		end
	end

	assign reg_a = regs[ctrl.ra];
	assign reg_b = regs[ctrl.rb];

	// Program counter, always one ahead of the executing word
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (jump_taken) begin
			pc <= alu_y;
		end else if (!mem_op) begin	// Hold for the refetch
			pc <= pc + 1'b1;
		end
	end

	assign pc_now = pc;

endmodule

//--- hdl/gus_core.sv
/*
 * Core top level
 *   decode, execute and result stages on one memory bus
 */
`timescale 1ns/100ps

module gus_core (
	input  logic                        clk,
	input  logic                        reset,
	output logic [core_pkg::WORD_W-1:0] mem_addr,
	output logic [core_pkg::WORD_W-1:0] mem_wdata,
	output logic                        mem_we,
	input  logic [core_pkg::WORD_W-1:0] mem_rdata
);
	import core_pkg::*;

	ctrl_t             ctrl;
	logic              op_valid, jump_taken, ld_st;
	logic [WORD_W-1:0] imm, alu_y;
	logic [WORD_W-1:0] reg_a, reg_b, pc_now;

	assign ld_st = op_valid && (ctrl.ld || ctrl.st);	// Memory cycle in progress

	gus_decode u_decode (
		.clk, .reset, .mem_rdata, .jump_taken, .ld_st,
		.ctrl, .op_valid, .imm
	);

	gus_execute u_execute (
		.clk, .reset, .ctrl, .op_valid, .imm, .reg_a, .reg_b, .pc_now,
		.mem_rdata, .alu_y, .mem_addr, .mem_we, .mem_wdata, .jump_taken
	);

	gus_result u_result (
		.clk, .reset, .ctrl, .op_valid, .alu_y, .jump_taken,
		.reg_a, .reg_b, .pc_now
	);

endmodule

//--- include/tb_asm.svh
/*
 * Assembler functions for test programs
 *   register, immediate, memory, rotate and misc formats
 *   conditional jump, JAL and JIND
 */
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// ADD group and logic group, fn picks the operation
function automatic logic [15:0] reg_insn(isa_pkg::op_major_t op, logic [2:0] rd,
	logic [2:0] ra, logic [2:0] rb, logic [1:0] fn);
	return {op, rd, ra, rb, fn};
endfunction

// ADDI to LDI, rd is also the A source
function automatic logic [15:0] imm_insn(isa_pkg::op_major_t op, logic [2:0] rd,
	logic [7:0] k);
	return {op, rd, k};
endfunction

// LD and ST, address = ra + off
function automatic logic [15:0] mem_insn(isa_pkg::op_major_t op, logic [2:0] rd,
	logic [2:0] ra, logic [4:0] off);
	return {op, rd, ra, off};
endfunction

function automatic logic [15:0] rori_insn(logic [2:0] rd, logic [2:0] rb, logic [3:0] n);
	return {isa_pkg::OP_MISC, rd, isa_pkg::SUB_MISC_ROT, n[3:2], rb, n[1:0]};
endfunction

// Shifts (SUB_SHIFT) and NOT/NEG (SUB_UNARY)
function automatic logic [15:0] misc_insn(logic [2:0] rd, logic [2:0] sub,
	logic [2:0] rb, logic [1:0] fn);
	return {isa_pkg::OP_MISC, rd, sub, rb, fn};
endfunction

function automatic logic [15:0] jump_insn(isa_pkg::cond_t cond, logic [11:0] off);
	logic [4:0] op;
	op = isa_pkg::OP_JUMP;
	return {op[4], cond, off};	// Only the jump flag of the opcode
endfunction

function automatic logic [15:0] jal_insn(logic [11:0] off);
	logic [4:0] op;
	op = isa_pkg::OP_JAL;
	return {op[4:1], off};	// Offset sign lands in bit 11
endfunction

// Target register sits in the rb field
function automatic logic [15:0] jind_insn(logic [2:0] rb);
	return {isa_pkg::OP_MISC, 3'b000, isa_pkg::SUB_JUMP, rb, 2'b10};
endfunction

`endif

//--- verif/tb_gus_core.sv
/*
 * Testbench for the core
 *   clock, reset and word memory model with store capture
 *   LFSR operand source and expected-store queues
 *   directed tests for ALU, immediates, shifts, jumps, LD/ST and JAL
 */
`timescale 1ns/100ps

module tb_gus_core;
	import isa_pkg::*;

	`include "tb_asm.svh"

	localparam logic [2:0] LINK_REG_IDX = 3'd6;

	logic        clk;
	logic        reset;
	logic [15:0] mem_addr;
	logic [15:0] mem_wdata;
	logic        mem_we;
	logic [15:0] mem_rdata;

	logic [15:0] mem [256];	// Word memory, low half holds the program
	logic [15:0] exp_a[$];
	logic [15:0] exp_d[$];
	logic [15:0] got_a[$];	// Captured stores
	logic [15:0] got_d[$];
	logic [31:0] lfsr;
	logic [7:0]  pc_w;	// Assembly write pointer
	int          errors;

	gus_core u_dut (
		.clk, .reset, .mem_addr, .mem_wdata, .mem_we, .mem_rdata
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Memory model
	assign mem_rdata = mem[mem_addr[7:0]];	// Combinational read

	always @(posedge clk) begin
		if (mem_we) begin
			mem[mem_addr[7:0]] = mem_wdata;
			got_a.push_back(mem_addr);
			got_d.push_back(mem_wdata);
		end
	end

	// Fill depends on all address bits
	function automatic logic [15:0] fill_word(logic [7:0] a);
		return {a ^ 8'h5a, ~a};
	endfunction

	// Galois LFSR, one step per bit
	function automatic logic [15:0] rand_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [16:0] add_c(logic [15:0] a, logic [15:0] b, logic ci);
		return {1'b0, a} + {1'b0, b} + {16'b0, ci};	// Carry out in bit 16
	endfunction

	// ------------------------------------------------------------------------
	// Program building and run control
	task automatic emit(logic [15:0] w);
		mem[pc_w] = w;
		pc_w++;
	endtask

	// Full word through LDI, byte swap, ORI
	task automatic load_word(logic [2:0] r, logic [15:0] v);
		emit(imm_insn(OP_LDI, r, v[15:8]));
		emit(rori_insn(r, r, 4'd8));
		emit(imm_insn(OP_ORI, r, v[7:0]));
	endtask

	task automatic store_at(logic [2:0] r, logic [4:0] off, logic [15:0] d);
		emit(mem_insn(OP_ST, r, 3'd5, off));	// R5 is the data base
		exp_a.push_back(16'h0080 + {11'b0, off});
		exp_d.push_back(d);
	endtask

	task automatic halt();
		emit(jump_insn(C_AL, 12'hfff));	// Jump to self
	endtask

	task automatic start_test();
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < 256; i++) begin
			mem[i[7:0]] = fill_word(i[7:0]);
		end
		exp_a.delete();
		exp_d.delete();
		got_a.delete();
		got_d.delete();
		pc_w = 8'h00;
		emit(imm_insn(OP_LDI, 3'd5, 8'h80));
	endtask

	task automatic run_test(string name);
		int n;
		int cycles;
		repeat (2) @(negedge clk);	// Reset held 2 cycles
		reset = 1'b0;
		#1;
		if (mem_we !== 1'b0) begin
			errors++;
			$display("[FAIL] %s mem_we after reset: got %h expected 0", name, mem_we);
		end
		if (mem_addr !== 16'h0000) begin
			errors++;
			$display("[FAIL] %s mem_addr after reset: got %h expected 0000", name, mem_addr);
		end
		n = exp_a.size();
		cycles = 0;
		while (got_a.size() < n && cycles < 1000) begin
			@(negedge clk);
			cycles++;
		end
		if (got_a.size() < n) begin
			errors++;
			$display("%s: timed out waiting for %0d stores, only %0d seen",
				name, n, got_a.size());
		end
		for (int i = 0; i < n && i < got_a.size(); i++) begin
			if (got_a[i] !== exp_a[i]) begin
				errors++;
				$display("[FAIL] %s mem_addr store %0d: got %h expected %h",
					name, i, got_a[i], exp_a[i]);
			end
			if (got_d[i] !== exp_d[i]) begin
				errors++;
				$display("[FAIL] %s mem_wdata store %0d: got %h expected %h",
					name, i, got_d[i], exp_d[i]);
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	task automatic alu_reg_ops();
		logic [15:0] a, b;
		logic [16:0] r;
		logic        c;
		start_test();
		a = rand_bits(16);
		b = rand_bits(16);
		load_word(3'd1, a);
		load_word(3'd2, b);
		emit(reg_insn(OP_ALU, 3'd3, 3'd1, 3'd2, 2'b00));	// ADD
		r = add_c(a, b, 1'b0);
		c = r[16];
		store_at(3'd3, 5'd0, r[15:0]);
		emit(reg_insn(OP_ALU, 3'd3, 3'd1, 3'd2, 2'b10));	// ADC, C from ADD
		r = add_c(a, b, c);
		store_at(3'd3, 5'd1, r[15:0]);
		emit(reg_insn(OP_ALU, 3'd3, 3'd1, 3'd2, 2'b01));	// SUB
		r = add_c(a, ~b, 1'b1);
		c = r[16];
		store_at(3'd3, 5'd2, r[15:0]);
		emit(reg_insn(OP_ALU, 3'd3, 3'd1, 3'd2, 2'b11));	// SBC, C from SUB
		r = add_c(a, ~b, c);
		store_at(3'd3, 5'd3, r[15:0]);
		emit(reg_insn(OP_LOGIC, 3'd3, 3'd1, 3'd2, 2'b00));
		store_at(3'd3, 5'd4, a & b);
		emit(reg_insn(OP_LOGIC, 3'd3, 3'd1, 3'd2, 2'b01));
		store_at(3'd3, 5'd5, a | b);
		emit(reg_insn(OP_LOGIC, 3'd3, 3'd1, 3'd2, 2'b10));
		store_at(3'd3, 5'd6, a ^ b);
		emit(reg_insn(OP_LOGIC, 3'd3, 3'd1, 3'd2, 2'b11));	// BIC
		store_at(3'd3, 5'd7, a & ~b);
		halt();
		run_test("alu_reg");
	endtask

	task automatic alu_imm_ops();
		logic [15:0] a;
		logic [7:0]  k;
		start_test();
		a = rand_bits(16);
		load_word(3'd1, a);
		k = rand_bits(8);
		emit(imm_insn(OP_ADDI, 3'd1, k));
		a = a + {8'h00, k};
		store_at(3'd1, 5'd0, a);
		k = rand_bits(8);
		emit(imm_insn(OP_SUBI, 3'd1, k));
		a = a - {8'h00, k};
		store_at(3'd1, 5'd1, a);
		k = rand_bits(8);
		emit(imm_insn(OP_ANDI, 3'd1, k));
		a = a & {8'h00, k};
		store_at(3'd1, 5'd2, a);
		k = rand_bits(8);
		emit(imm_insn(OP_ORI, 3'd1, k));
		a = a | {8'h00, k};
		store_at(3'd1, 5'd3, a);
		k = rand_bits(8);
		emit(imm_insn(OP_XORI, 3'd1, k));
		a = a ^ {8'h00, k};
		store_at(3'd1, 5'd4, a);
		// CMPI sets Z but leaves R2
		k = rand_bits(8);
		emit(imm_insn(OP_LDI, 3'd4, 8'haa));
		emit(imm_insn(OP_LDI, 3'd2, k));
		emit(imm_insn(OP_CMPI, 3'd2, k));
		emit(jump_insn(C_Z, 12'd1));	// Skips the next LDI
		emit(imm_insn(OP_LDI, 3'd4, 8'h55));
		store_at(3'd4, 5'd5, 16'h00aa);
		store_at(3'd2, 5'd6, {8'h00, k});
		emit(imm_insn(OP_CMPI, 3'd1, rand_bits(8)));
		store_at(3'd1, 5'd7, a);
		halt();
		run_test("alu_imm");
	endtask

	task automatic shift_ops();
		logic [15:0] b;
		logic [31:0] t;
		start_test();
		b = rand_bits(15);
		b[15] = 1'b1;	// Sign set for SHRA
		load_word(3'd1, b);
		for (int n = 0; n < 16; n++) begin
			emit(rori_insn(3'd3, 3'd1, n[3:0]));
			t = {b, b} >> n;
			store_at(3'd3, n[4:0], t[15:0]);
		end
		emit(misc_insn(3'd3, SUB_SHIFT, 3'd1, 2'b01));	// SHR
		store_at(3'd3, 5'd16, {1'b0, b[15:1]});
		emit(misc_insn(3'd3, SUB_SHIFT, 3'd1, 2'b10));	// SHRA, C = b[0]
		store_at(3'd3, 5'd17, {b[15], b[15:1]});
		emit(misc_insn(3'd3, SUB_SHIFT, 3'd1, 2'b00));	// RORC
		store_at(3'd3, 5'd18, {b[0], b[15:1]});
		emit(misc_insn(3'd3, SUB_UNARY, 3'd1, 2'b00));	// NOT
		store_at(3'd3, 5'd19, ~b);
		emit(misc_insn(3'd3, SUB_UNARY, 3'd1, 2'b01));	// NEG
		store_at(3'd3, 5'd20, 16'h0000 - b);
		halt();
		run_test("shift");
	endtask

	// Marker 1 equal, 2 less, 3 greater
	task automatic cmp_block(logic [7:0] k, logic [4:0] off, logic [15:0] marker);
		emit(imm_insn(OP_CMPI, 3'd1, k));
		emit(jump_insn(C_Z, 12'd5));
		emit(jump_insn(C_NC, 12'd2));	// Borrow means less
		emit(imm_insn(OP_LDI, 3'd4, 8'd3));
		emit(jump_insn(C_AL, 12'd3));
		emit(imm_insn(OP_LDI, 3'd4, 8'd2));
		emit(jump_insn(C_AL, 12'd1));
		emit(imm_insn(OP_LDI, 3'd4, 8'd1));
		store_at(3'd4, off, marker);
	endtask

	task automatic cond_jumps();
		start_test();
		emit(imm_insn(OP_LDI, 3'd1, 8'h40));
		cmp_block(8'h40, 5'd0, 16'd1);
		cmp_block(8'h50, 5'd1, 16'd2);
		cmp_block(8'h30, 5'd2, 16'd3);
		halt();
		run_test("jump");
	endtask

	task automatic mem_and_call();
		logic [7:0] jal_at;
		start_test();
		emit(mem_insn(OP_LD, 3'd2, 3'd5, 5'd19));	// From 0x93
		store_at(3'd2, 5'd0, fill_word(8'h93));
		emit(mem_insn(OP_LD, 3'd3, 3'd5, 5'd31));
		store_at(3'd3, 5'd1, fill_word(8'h9f));
		jal_at = pc_w;
		emit(jal_insn(12'd3));	// Call past the halt
		emit(imm_insn(OP_LDI, 3'd4, 8'h66));	// Return lands here
		emit(mem_insn(OP_ST, 3'd4, 3'd5, 5'd4));
		halt();
		store_at(3'd6, 5'd2, {8'h00, jal_at + 8'd1});	// Link word
		emit(imm_insn(OP_LDI, 3'd4, 8'h77));
		store_at(3'd4, 5'd3, 16'h0077);
		emit(jind_insn(LINK_REG_IDX));
		exp_a.push_back(16'h0084);	// Store after the return comes last
		exp_d.push_back(16'h0066);
		run_test("mem_call");
	endtask

	// ------------------------------------------------------------------------
	initial begin
		reset = 1'b1;
		lfsr = 32'hdf48_a6de;
		errors = 0;
		pc_w = 8'h00;
		alu_reg_ops();
		alu_imm_ops();
		shift_ops();
		cond_jumps();
		mem_and_call();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+include
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/gus_decode.sv
hdl/gus_execute.sv
hdl/gus_result.sv
hdl/gus_core.sv
verif/tb_gus_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_gus_core -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "all tests passed"
